// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_opq
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hdl/operand_queue.sv
// Lane operand queue
module operand_queue import opq_pkg::*; #(
  parameter  int unsigned BufferDepth    = 2,
  parameter  int unsigned NrSlaves       = 1,
  parameter  int unsigned NrLanes        = 1,
  parameter  logic        SupportIntExt2 = 1'b0,
  parameter  logic        SupportIntExt4 = 1'b0,
  parameter  logic        SupportIntExt8 = 1'b0,
  localparam int unsigned LaneIdW        = (NrLanes > 1) ? $clog2(NrLanes) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [LaneIdW-1:0]  lane_id_i,
  input  opq_cmd_t            cmd_i,
  input  logic                cmd_valid_i,
  input  elen_t               operand_i,
  input  logic                operand_valid_i,
  input  logic                operand_issued_i,
  output logic                operand_queue_ready_o,
  output elen_t               operand_o,
  output logic                operand_valid_o,
  input  logic [NrSlaves-1:0] operand_ready_i
);

  localparam int unsigned CntW = $clog2(BufferDepth + 1);
  localparam int unsigned SumW = VlBits + 1;

  logic            lane_zero;
  opq_cmd_t        cmd;
  logic            cmd_empty, cmd_pop;
  elen_t           ibuf_word;
  logic            ibuf_empty, ibuf_pop;
  logic [CntW-1:0] credit_q, inflight_q;
  logic [2:0]      chunk_d, chunk_q;
  vlen_t           vl_d, vl_q;
  logic [1:0]      ext_lf;
  logic            ext_on, last_chunk, beat_fire;
  logic [3:0]      elems;
  logic [SumW-1:0] vl_sum;

  assign lane_zero = (lane_id_i == '0);

  opq_fifo #(.Depth(BufferDepth), .dtype(opq_cmd_t)) u_cmd_fifo (
    .clk_i(clk_i), .rst_ni(rst_ni), .push_i(cmd_valid_i), .data_i(cmd_i),
    .pop_i(cmd_pop), .data_o(cmd), .full_o(), .empty_o(cmd_empty)
  );

  opq_fifo #(.Depth(BufferDepth), .dtype(elen_t)) u_ibuf_fifo (
    .clk_i(clk_i), .rst_ni(rst_ni), .push_i(operand_valid_i), .data_i(operand_i),
    .pop_i(ibuf_pop), .data_o(ibuf_word), .full_o(), .empty_o(ibuf_empty)
  );

  //////////////////////////////
  // Credit counter
  //////////////////////////////

  // Credits cover words in flight and words already buffered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q   <= '0;
      inflight_q <= '0;
    end else begin
      credit_q   <= credit_q + CntW'(operand_issued_i) - CntW'(ibuf_pop);
      inflight_q <= inflight_q + CntW'(operand_issued_i) - CntW'(operand_valid_i);
    end
  end

  assign operand_queue_ready_o = (credit_q < CntW'(BufferDepth));

  opq_convert #(
    .SupportIntExt2(SupportIntExt2), .SupportIntExt4(SupportIntExt4),
    .SupportIntExt8(SupportIntExt8)
  ) u_convert (
    .word_i(ibuf_word), .conv_i(cmd.conv), .eew_i(cmd.eew), .chunk_i(chunk_q),
    .lane_zero_i(lane_zero), .ntr_red_i(cmd.ntr_red), .word_o(operand_o)
  );

  assign operand_valid_o = !ibuf_empty;
  assign beat_fire       = operand_valid_o && |operand_ready_i;

  //////////////////////////////
  // Beat and element accounting
  //////////////////////////////

  assign ext_lf     = opq_ext_log2(cmd.conv);
  assign ext_on     = opq_ext_legal(ext_lf, cmd.eew, SupportIntExt2, SupportIntExt4,
                                    SupportIntExt8);
  assign last_chunk = !ext_on || ({1'b0, chunk_q} == ((4'd1 << ext_lf) - 4'd1));

  always_comb begin
    // Source elements covered by one beat
    if (cmd.conv == OpqRedZExt) elems = 4'd1;
    else if (ext_on)            elems = (4'd8 >> cmd.eew) >> ext_lf;
    else                        elems = 4'd8 >> cmd.eew;

    vl_sum   = {1'b0, vl_q} + SumW'(elems);
    chunk_d  = chunk_q;
    vl_d     = vl_q;
    ibuf_pop = 1'b0;
    cmd_pop  = 1'b0;
    if (beat_fire) begin
      ibuf_pop = last_chunk;
      chunk_d  = last_chunk ? 3'd0 : chunk_q + 3'd1;
      vl_d     = vl_sum[VlBits-1:0];
      // Command done even in the middle of a word
      if (vl_sum >= {1'b0, cmd.vl}) begin
        ibuf_pop = 1'b1;
        cmd_pop  = 1'b1;
        chunk_d  = '0;
        vl_d     = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chunk_q <= '0;
      vl_q    <= '0;
    end else begin
      chunk_q <= chunk_d;
      vl_q    <= vl_d;
    end
  end

  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CntW'(BufferDepth)) else $error("Credit count above buffer depth");
  a_valid_has_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_valid_o |-> !cmd_empty) else $error("Operand valid without a command");
  a_word_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_valid_i |-> inflight_q != '0) else $error("Operand word without a credit");

endmodule

// File: hdl/opq_convert.sv
// Operand word widening
module opq_convert import opq_pkg::*; #(
  parameter logic SupportIntExt2 = 1'b0,
  parameter logic SupportIntExt4 = 1'b0,
  parameter logic SupportIntExt8 = 1'b0
) (
  input  elen_t      word_i,
  input  opq_conv_e  conv_i,
  input  ew_e        eew_i,
  input  logic [2:0] chunk_i,
  input  logic       lane_zero_i,
  input  logic [1:0] ntr_red_i,
  output elen_t      word_o
);

  logic [1:0] ext_lf;
  logic       ext_sign;
  logic       ext_on;

  // Widen each element of the selected chunk by 2**lf
  function automatic elen_t widen(elen_t word, int unsigned lf, ew_e eew,
                                  logic [2:0] chunk, logic sext);
    elen_t       res;
    int unsigned sl;
    int unsigned dl;
    int unsigned base;
    int unsigned e;
    int unsigned k;
    int unsigned src;
    sl   = 3 + int'(eew);
    dl   = sl + lf;
    base = (int'(chunk) & ((1 << lf) - 1)) << (6 - lf);
    for (int b = 0; b < ElenBits; b++) begin
      e = b >> dl;
      k = b - (e << dl);
      if (k < (1 << sl)) begin
        src    = base + (e << sl) + k;
        res[b] = word[src];
      end else begin
        // Top bit of the source element
        src    = base + (e << sl) + (1 << sl) - 1;
        res[b] = sext & word[src];
      end
    end
    return res;
  endfunction

  // Neutral fill per element with an optional kept lowest element
  function automatic elen_t reduce_fill(elen_t word, ew_e eew, logic keep_low,
                                        logic [1:0] ntr);
    elen_t       res;
    int unsigned sl;
    int unsigned k;
    sl = 3 + int'(eew);
    for (int b = 0; b < ElenBits; b++) begin
      k = b & ((1 << sl) - 1);
      if (keep_low && (b < (1 << sl))) begin
        res[b] = word[b];
      end else if (k == (1 << sl) - 1) begin
        res[b] = ntr[1];
      end else begin
        res[b] = ntr[0];
      end
    end
    return res;
  endfunction

  //////////////////////////////
  // Conversion decode
  //////////////////////////////

  assign ext_lf   = opq_ext_log2(conv_i);
  assign ext_sign = conv_i inside {OpqSExt2, OpqSExt4, OpqSExt8};
  assign ext_on   = opq_ext_legal(ext_lf, eew_i, SupportIntExt2, SupportIntExt4,
                                  SupportIntExt8);

  always_comb begin
    if (conv_i == OpqRedZExt) begin
      word_o = reduce_fill(word_i, eew_i, lane_zero_i, ntr_red_i);
    end else if (ext_on) begin
      word_o = widen(word_i, ext_lf, eew_i, chunk_i, ext_sign);
    end else begin
      // Pass through also for disabled or oversized widening
      word_o = word_i;
    end
  end

endmodule

// File: hdl/opq_fifo.sv
// Circular buffer FIFO
module opq_fifo #(
  parameter int unsigned Depth = 2,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  dtype            mem_q [Depth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  // Oldest entry always visible
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("FIFO push while full");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("FIFO pop while empty");

endmodule

// File: hdl/opq_pkg.sv
// Operand queue shared definitions
package opq_pkg;

  localparam int unsigned ElenBits = 64;
  localparam int unsigned VlBits   = 16;

  typedef logic [ElenBits-1:0] elen_t;
  typedef logic [VlBits-1:0]   vlen_t;

  typedef enum logic [1:0] {
    EW8, EW16, EW32, EW64
  } ew_e;

  typedef enum logic [2:0] {
    OpqConvNone,
    OpqSExt2, OpqSExt4, OpqSExt8,
    OpqZExt2, OpqZExt4, OpqZExt8,
    OpqRedZExt
  } opq_conv_e;

  // One command per vector instruction
  typedef struct packed {
    opq_conv_e  conv;
    ew_e        eew;
    vlen_t      vl;
    logic [1:0] ntr_red;
  } opq_cmd_t;

  // Log2 of the widening factor or zero for non-extending conversions
  function automatic logic [1:0] opq_ext_log2(opq_conv_e conv);
    case (conv)
      OpqSExt2, OpqZExt2: return 2'd1;
      OpqSExt4, OpqZExt4: return 2'd2;
      OpqSExt8, OpqZExt8: return 2'd3;
      default:            return 2'd0;
    endcase
  endfunction

  // Factor enabled and widened element still fits in one word
  function automatic logic opq_ext_legal(logic [1:0] lf, ew_e eew,
                                         logic s2, logic s4, logic s8);
    logic supported;
    case (lf)
      2'd1:    supported = s2;
      2'd2:    supported = s4;
      2'd3:    supported = s8;
      default: supported = 1'b0;
    endcase
    return supported && (({1'b0, eew} + {1'b0, lf}) <= 3'd3);
  endfunction

endpackage

// File: hdl/opq_top.sv
// Operand queue top level
module opq_top import opq_pkg::*; #(
  parameter  int unsigned BufferDepth    = 2,
  parameter  int unsigned NrSlaves       = 2,
  parameter  int unsigned NrLanes        = 4,
  parameter  logic        SupportIntExt2 = 1'b1,
  parameter  logic        SupportIntExt4 = 1'b1,
  parameter  logic        SupportIntExt8 = 1'b1,
  localparam int unsigned LaneIdW        = (NrLanes > 1) ? $clog2(NrLanes) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [LaneIdW-1:0]  lane_id_i,
  input  opq_cmd_t            cmd_i,
  input  logic                cmd_valid_i,
  input  elen_t               operand_i,
  input  logic                operand_valid_i,
  input  logic                operand_issued_i,
  output logic                operand_queue_ready_o,
  output elen_t               operand_o,
  output logic                operand_valid_o,
  input  logic [NrSlaves-1:0] operand_ready_i
);

  operand_queue #(
    .BufferDepth(BufferDepth), .NrSlaves(NrSlaves), .NrLanes(NrLanes),
    .SupportIntExt2(SupportIntExt2), .SupportIntExt4(SupportIntExt4),
    .SupportIntExt8(SupportIntExt8)
  ) u_queue (
    .clk_i(clk_i), .rst_ni(rst_ni), .lane_id_i(lane_id_i),
    .cmd_i(cmd_i), .cmd_valid_i(cmd_valid_i),
    .operand_i(operand_i), .operand_valid_i(operand_valid_i),
    .operand_issued_i(operand_issued_i), .operand_queue_ready_o(operand_queue_ready_o),
    .operand_o(operand_o), .operand_valid_o(operand_valid_o),
    .operand_ready_i(operand_ready_i)
  );

endmodule

// File: src.f
hdl/opq_pkg.sv
hdl/opq_fifo.sv
hdl/opq_convert.sv
hdl/operand_queue.sv
hdl/opq_top.sv
testbench/tb_opq.sv

// File: testbench/tb_opq.sv
// Operand queue testbench
module tb_opq import opq_pkg::*; ();

  localparam int Seed      = 32'h7a8d_0215;
  // About 500 cycles of tests plus margin
  localparam int MaxCycles = 2000;

  logic       clk_i;
  logic       rst_ni;
  logic [1:0] lane_id_i;
  opq_cmd_t   cmd_i;
  logic       cmd_valid_i;
  elen_t      operand_i;
  logic       operand_valid_i;
  logic       operand_issued_i;
  logic       operand_queue_ready_o;
  elen_t      operand_o;
  logic       operand_valid_o;
  logic [1:0] operand_ready_i;

  integer seed  = Seed;
  integer rseed = Seed;
  int     data_errs;
  int     ctrl_errs;
  int     cycles;
  // Ready source 0 is random, 1 held low and 2 all units ready
  int     ready_mode;
  int     mode_s;
  elen_t  exp_q[$];
  elen_t  exp_word;
  logic   exp_valid;

  opq_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [63:0] low_mask(int bits);
    return (bits >= 64) ? '1 : ((64'd1 << bits) - 64'd1);
  endfunction

  function automatic int ext_factor(opq_conv_e conv);
    case (conv)
      OpqSExt2, OpqZExt2: return 2;
      OpqSExt4, OpqZExt4: return 4;
      OpqSExt8, OpqZExt8: return 8;
      default:            return 1;
    endcase
  endfunction

  // Expected beat for one chunk of an input word
  function automatic elen_t expected_beat(opq_cmd_t c, elen_t w, int chunk, logic lane0);
    elen_t res;
    elen_t el;
    int    sw;
    int    f;
    int    dw;
    sw  = 8 << int'(c.eew);
    f   = ext_factor(c.conv);
    dw  = sw * f;
    res = '0;
    if (c.conv == OpqRedZExt) begin
      for (int e = 0; e < 64 / sw; e++) begin
        el         = c.ntr_red[0] ? low_mask(sw - 1) : '0;
        el[sw - 1] = c.ntr_red[1];
        res |= el << (e * sw);
      end
      if (lane0) begin
        res = (res & ~low_mask(sw)) | (w & low_mask(sw));
      end
    end else if (f == 1) begin
      res = w;
    end else begin
      for (int e = 0; e < 64 / dw; e++) begin
        el = (w >> (chunk * (64 / f) + e * sw)) & low_mask(sw);
        if ((c.conv inside {OpqSExt2, OpqSExt4, OpqSExt8}) && el[sw - 1]) begin
          el |= ~low_mask(sw);
        end
        res |= (el & low_mask(dw)) << (e * dw);
      end
    end
    return res;
  endfunction

  function automatic void refresh_expected();
    exp_valid = (exp_q.size() != 0);
    exp_word  = exp_valid ? exp_q[0] : '0;
  endfunction

  function automatic opq_cmd_t make_cmd(opq_conv_e conv, ew_e eew, int vl, logic [1:0] ntr);
    opq_cmd_t c;
    c.conv    = conv;
    c.eew     = eew;
    c.vl      = vlen_t'(vl);
    c.ntr_red = ntr;
    return c;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_cmd(opq_cmd_t c);
    cmd_i       = c;
    cmd_valid_i = 1'b1;
    next_cycle();
    cmd_valid_i = 1'b0;
  endtask

  // Issue pulse first and the word itself one cycle later
  task automatic send_word(elen_t w);
    while (!operand_queue_ready_o) begin
      next_cycle();
    end
    operand_issued_i = 1'b1;
    next_cycle();
    operand_issued_i = 1'b0;
    operand_i        = w;
    operand_valid_i  = 1'b1;
    next_cycle();
    operand_valid_i  = 1'b0;
  endtask

  task automatic feed(opq_cmd_t c);
    elen_t w;
    int    epb;
    int    bpw;
    int    beats;
    bpw   = ext_factor(c.conv);
    epb   = (c.conv == OpqRedZExt) ? 1 : (8 >> int'(c.eew)) / bpw;
    beats = (int'(c.vl) + epb - 1) / epb;
    w     = '0;
    for (int b = 0; b < beats; b++) begin
      if (b % bpw == 0) begin
        w = {$random(seed), $random(seed)};
      end
      exp_q.push_back(expected_beat(c, w, b % bpw, lane_id_i == 2'd0));
      refresh_expected();
      // Last chunk or the command ends mid-word
      if ((b % bpw == bpw - 1) || (b == beats - 1)) begin
        send_word(w);
      end
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  always @(posedge clk_i) begin
    mode_s = ready_mode;
    #1;
    operand_ready_i = (mode_s == 1) ? 2'b00 : (mode_s == 2) ? 2'b11 : 2'($random(rseed));
  end

  // Consumed beats leave the model
  always @(posedge clk_i) begin
    if (rst_ni && operand_valid_o && (operand_ready_i != '0) && exp_valid) begin
      exp_q.delete(0);
      refresh_expected();
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_beat_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_valid_o && operand_ready_i != '0) |-> (exp_valid && operand_o == exp_word))
    else begin
      data_errs++;
      $display("** Error %0t: beat %h, expected %h", $time, $sampled(operand_o),
               $sampled(exp_word));
    end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_valid_o && operand_ready_i == '0) |=> (operand_valid_o && $stable(operand_o)))
    else begin
      ctrl_errs++;
      $display("** Error %0t: operand changed while no unit was ready", $time);
    end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    opq_cmd_t c1;
    opq_cmd_t c2;
    int       lf;
    rst_ni           = 1'b0;
    lane_id_i        = 2'd0;
    cmd_i            = '0;
    cmd_valid_i      = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = '0;
    ready_mode       = 0;
    data_errs        = 0;
    ctrl_errs        = 0;
    cycles           = 0;
    refresh_expected();
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();
    assert (!operand_valid_o && operand_queue_ready_o) else begin
      ctrl_errs++;
      $display("** Error %0t: wrong valid or ready after reset", $time);
    end

    // Credits run out while no unit takes a beat
    ready_mode = 1;
    c1 = make_cmd(OpqConvNone, EW64, 2, 2'b00);
    send_cmd(c1);
    feed(c1);
    assert (!operand_queue_ready_o) else begin
      ctrl_errs++;
      $display("** Error %0t: queue ready with all credits taken", $time);
    end
    ready_mode = 2;
    next_cycle();
    assert (!operand_queue_ready_o) else begin
      ctrl_errs++;
      $display("** Error %0t: credit returned before any pop", $time);
    end
    next_cycle();
    assert (operand_queue_ready_o) else begin
      ctrl_errs++;
      $display("** Error %0t: credit not returned by word pop", $time);
    end
    ready_mode = 0;
    drain();

    // Two pass-through commands back to back
    for (int e = 0; e < 4; e++) begin
      c1 = make_cmd(OpqConvNone, ew_e'(e), 2 * (8 >> e) - 1, 2'b00);
      c2 = make_cmd(OpqConvNone, ew_e'(e), (8 >> e) + 1, 2'b00);
      send_cmd(c1);
      send_cmd(c2);
      feed(c1);
      feed(c2);
      drain();
    end

    // Sign and zero extension for every legal width
    for (int k = 1; k <= 6; k++) begin
      lf = ((k - 1) % 3) + 1;
      for (int e = 0; e + lf <= 3; e++) begin
        c1 = make_cmd(opq_conv_e'(k), ew_e'(e), 1 + ($unsigned($random(seed)) % (16 >> e)),
                      2'b00);
        send_cmd(c1);
        feed(c1);
        drain();
      end
    end

    // Reduction fill in lane zero and in another lane
    for (int l = 0; l < 2; l++) begin
      lane_id_i = (l == 0) ? 2'd0 : 2'd2;
      for (int n = 0; n < 4; n++) begin
        c1 = make_cmd(OpqRedZExt, ew_e'(n), 2, n[1:0]);
        send_cmd(c1);
        feed(c1);
        drain();
      end
    end

    repeat (4) next_cycle();
    assert (!operand_valid_o) else begin
      ctrl_errs++;
      $display("** Error %0t: operand still valid after the last command", $time);
    end
    $display("Errors: data %0d, control %0d", data_errs, ctrl_errs);
    if (data_errs + ctrl_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
